//--- hw/cpu_pkg.sv
////////////////////////////////////////
// CPU package
// Opcodes, ALU ops, widths and the bit positions of the pipeline bundles
////////////////////////////////////////
`default_nettype none

package cpu_pkg;

  localparam int DATA_W   = 16;  // Data and PC width
  localparam int REG_W    = 4;   // Register index width
  localparam int ALU_OP_W = 4;

  // Instruction opcodes, bits [15:12]
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_SLL  = 4'h6,
    OP_SRL  = 4'h7,
    OP_ADDI = 4'h8,
    OP_LI   = 4'h9,
    OP_LD   = 4'ha,
    OP_ST   = 4'hb,
    OP_BEQ  = 4'hc
  } opcode_e;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
  } alu_op_e;

  ////////////////////////////////////////
  // Bundle widths and field positions
  ////////////////////////////////////////
  localparam int EX_W  = ALU_OP_W + 3 * DATA_W + 2;  // 54
  localparam int MEM_W = DATA_W + 2;                 // 18
  localparam int WB_W  = REG_W + 2;                  // 6

  localparam int EX_ALU_LSB    = 50;  // ALU op [53:50]
  localparam int EX_OPA_LSB    = 34;  // Operand A [49:34]
  localparam int EX_OPB_LSB    = 18;  // Operand B [33:18]
  localparam int EX_IMM_LSB    = 2;   // Immediate [17:2]
  localparam int EX_USE_IMM    = 1;
  localparam int EX_IS_BR      = 0;
  localparam int MEM_SDATA_LSB = 2;   // Store data [17:2]
  localparam int MEM_RD        = 1;
  localparam int MEM_WR        = 0;
  localparam int WB_DST_LSB    = 2;   // Destination [5:2]
  localparam int WB_REG_WR     = 1;
  localparam int WB_FROM_MEM   = 0;

endpackage

`default_nettype wire

//--- hw/reg_file.sv
////////////////////////////////////////
// Register file
// 16 x 16, two combinational reads, one write, write-through
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [cpu_pkg::REG_W-1:0]  rs1_idx,   // Read port 1 index
  input  logic [cpu_pkg::REG_W-1:0]  rs2_idx,   // Read port 2 index
  input  logic                       wr_en,     // Writeback enable
  input  logic [cpu_pkg::REG_W-1:0]  wr_idx,
  input  logic [cpu_pkg::DATA_W-1:0] wr_data,
  output logic [cpu_pkg::DATA_W-1:0] rs1_data,
  output logic [cpu_pkg::DATA_W-1:0] rs2_data
);

  logic [cpu_pkg::DATA_W-1:0] regs [1 << cpu_pkg::REG_W];  // Register 0 is not hardwired

  // Write port, whole file cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << cpu_pkg::REG_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Bypass the value being written this cycle
  assign rs1_data = (wr_en && wr_idx == rs1_idx) ? wr_data : regs[rs1_idx];
  assign rs2_data = (wr_en && wr_idx == rs2_idx) ? wr_data : regs[rs2_idx];

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
////////////////////////////////////////
// Instruction decoder
// Splits the word into EX, MEM and WB bundles, drives register reads
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic [15:0]                instr,
  output logic [cpu_pkg::REG_W-1:0]  rs1_idx,
  output logic [cpu_pkg::REG_W-1:0]  rs2_idx,
  input  logic [cpu_pkg::DATA_W-1:0] rs1_data,
  input  logic [cpu_pkg::DATA_W-1:0] rs2_data,
  output logic [cpu_pkg::EX_W-1:0]   ex_bundle,
  output logic [cpu_pkg::MEM_W-1:0]  mem_bundle,
  output logic [cpu_pkg::WB_W-1:0]   wb_bundle,
  output logic                       src1_used,  // rs1 is read by this instruction
  output logic                       src2_used   // Port 2 is read by this instruction
);

  cpu_pkg::opcode_e           opcode;
  cpu_pkg::alu_op_e           alu_op;
  logic [cpu_pkg::DATA_W-1:0] imm;
  logic [cpu_pkg::DATA_W-1:0] opa;
  logic                       use_imm, is_branch;
  logic                       mem_rd, mem_wr, reg_wr, from_mem;

  assign opcode  = cpu_pkg::opcode_e'(instr[15:12]);
  assign rs1_idx = instr[7:4];
  // ST and BEQ read their second source from the rd field
  assign rs2_idx = (opcode == cpu_pkg::OP_ST || opcode == cpu_pkg::OP_BEQ) ? instr[11:8]
                                                                           : instr[3:0];

  always_comb begin
    alu_op    = cpu_pkg::ALU_ADD;
    imm       = {{12{instr[3]}}, instr[3:0]};  // imm4, sign-extended
    opa       = rs1_data;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    reg_wr    = 1'b0;
    from_mem  = 1'b0;
    src1_used = 1'b1;
    src2_used = 1'b0;
    case (opcode)
      cpu_pkg::OP_ADD: begin alu_op = cpu_pkg::ALU_ADD; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_SUB: begin alu_op = cpu_pkg::ALU_SUB; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_AND: begin alu_op = cpu_pkg::ALU_AND; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_OR:  begin alu_op = cpu_pkg::ALU_OR;  reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_XOR: begin alu_op = cpu_pkg::ALU_XOR; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_SLL: begin alu_op = cpu_pkg::ALU_SLL; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_SRL: begin alu_op = cpu_pkg::ALU_SRL; reg_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_ADDI: begin use_imm = 1'b1; reg_wr = 1'b1; end
      cpu_pkg::OP_LI: begin
        imm       = {{8{instr[7]}}, instr[7:0]};  // imm8 added to zero
        opa       = '0;
        use_imm   = 1'b1;
        reg_wr    = 1'b1;
        src1_used = 1'b0;
      end
      cpu_pkg::OP_LD: begin use_imm = 1'b1; mem_rd = 1'b1; reg_wr = 1'b1; from_mem = 1'b1; end
      cpu_pkg::OP_ST: begin use_imm = 1'b1; mem_wr = 1'b1; src2_used = 1'b1; end
      cpu_pkg::OP_BEQ: begin is_branch = 1'b1; src2_used = 1'b1; end  // Compare rd with rs1
      default: src1_used = 1'b0;  // NOP and unused codes, all controls low
    endcase
  end

  // Pack the bundles in package field order
  assign ex_bundle  = {alu_op, opa, rs2_data, imm, use_imm, is_branch};
  assign mem_bundle = {rs2_data, mem_rd, mem_wr};
  assign wb_bundle  = {instr[11:8], reg_wr, from_mem};

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
////////////////////////////////////////
// Hazard unit
// RAW interlock against in-flight writers, stall and flush
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  logic [cpu_pkg::REG_W-1:0] src1_idx,
  input  logic [cpu_pkg::REG_W-1:0] src2_idx,
  input  logic                      src1_used,
  input  logic                      src2_used,
  input  logic [cpu_pkg::WB_W-1:0]  id_ex_wb,      // Writer now in execute
  input  logic [cpu_pkg::WB_W-1:0]  ex_mem_wb,     // Writer now in writeback
  input  logic                      branch_taken,
  input  logic                      hold,          // Whole pipeline frozen
  output logic                      stall,
  output logic                      flush
);

  logic raw;  // Decode reads a register still in flight

  function automatic logic writes_reg(input logic [cpu_pkg::REG_W-1:0] idx,
                                      input logic [cpu_pkg::WB_W-1:0]  wb);
    return wb[cpu_pkg::WB_REG_WR] && (wb[cpu_pkg::WB_DST_LSB +: cpu_pkg::REG_W] == idx);
  endfunction

  assign raw = (src1_used && (writes_reg(src1_idx, id_ex_wb) || writes_reg(src1_idx, ex_mem_wb)))
            || (src2_used && (writes_reg(src2_idx, id_ex_wb) || writes_reg(src2_idx, ex_mem_wb)));

  assign stall = raw & ~hold;
  assign flush = ~hold & (stall | branch_taken);  // Bubble into ID/EX

endmodule

`default_nettype wire

//--- hw/id_ex_pipe_reg.sv
////////////////////////////////////////
// ID/EX pipeline register
// Holds on stall, control bundles cleared on flush or reset
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module id_ex_pipe_reg (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stall,              // Keep current contents
  input  logic                       flush,              // Load a bubble
  input  logic [cpu_pkg::DATA_W-1:0] pc_next,
  input  logic [cpu_pkg::EX_W-1:0]   ex_signals,
  input  logic [cpu_pkg::MEM_W-1:0]  mem_signals,
  input  logic [cpu_pkg::WB_W-1:0]   wb_signals,
  output logic [cpu_pkg::DATA_W-1:0] id_ex_pc_next,
  output logic [cpu_pkg::EX_W-1:0]   id_ex_ex_signals,
  output logic [cpu_pkg::MEM_W-1:0]  id_ex_mem_signals,
  output logic [cpu_pkg::WB_W-1:0]   id_ex_wb_signals
);

  logic wen;  // Load enable
  logic clr;  // Bubble, flush wins over stall

  assign wen = ~stall;
  assign clr = flush | rst;

  // Next PC, only reset clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_pc_next <= '0;
    end else if (wen) begin
      id_ex_pc_next <= pc_next;
    end
  end

  ////////////////////////////////////////
  // Control bundles
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clr) begin
      id_ex_ex_signals <= '0;  // ALU op, operands, imm, flags
    end else if (wen) begin
      id_ex_ex_signals <= ex_signals;
    end
  end

  always_ff @(posedge clk) begin
    if (clr) begin
      id_ex_mem_signals <= '0;
    end else if (wen) begin
      id_ex_mem_signals <= mem_signals;
    end
  end

  always_ff @(posedge clk) begin
    if (clr) begin
      id_ex_wb_signals <= '0;
    end else if (wen) begin
      id_ex_wb_signals <= wb_signals;
    end
  end

  // Flush is gated by hold upstream, so a bubble never meets a freeze here
  assert property (@(posedge clk) disable iff (rst) !(flush && stall))
    else $error("id_ex_pipe_reg: flush and stall raised together");

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
////////////////////////////////////////
// Execute unit
// Operand select, ALU and BEQ resolution
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  logic [cpu_pkg::EX_W-1:0]   ex_signals,
  input  logic [cpu_pkg::MEM_W-1:0]  mem_signals,
  input  logic [cpu_pkg::WB_W-1:0]   wb_signals,
  input  logic [cpu_pkg::DATA_W-1:0] id_ex_pc_next,
  output logic [cpu_pkg::DATA_W-1:0] alu_result,     // Also the data memory address
  output logic                       branch_taken,
  output logic [cpu_pkg::DATA_W-1:0] branch_target,
  output logic [cpu_pkg::MEM_W-1:0]  mem_out,
  output logic [cpu_pkg::WB_W-1:0]   wb_out
);

  cpu_pkg::alu_op_e           alu_op;
  logic [cpu_pkg::DATA_W-1:0] opa, opb, imm;
  logic [cpu_pkg::DATA_W-1:0] opb_sel;  // Second ALU input
  logic                       use_imm, is_branch;

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////
  assign alu_op    = cpu_pkg::alu_op_e'(ex_signals[cpu_pkg::EX_ALU_LSB +: cpu_pkg::ALU_OP_W]);
  assign opa       = ex_signals[cpu_pkg::EX_OPA_LSB +: cpu_pkg::DATA_W];
  assign opb       = ex_signals[cpu_pkg::EX_OPB_LSB +: cpu_pkg::DATA_W];
  assign imm       = ex_signals[cpu_pkg::EX_IMM_LSB +: cpu_pkg::DATA_W];
  assign use_imm   = ex_signals[cpu_pkg::EX_USE_IMM];
  assign is_branch = ex_signals[cpu_pkg::EX_IS_BR];

  assign opb_sel = use_imm ? imm : opb;

  // ALU
  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_ADD: alu_result = opa + opb_sel;
      cpu_pkg::ALU_SUB: alu_result = opa - opb_sel;
      cpu_pkg::ALU_AND: alu_result = opa & opb_sel;
      cpu_pkg::ALU_OR:  alu_result = opa | opb_sel;
      cpu_pkg::ALU_XOR: alu_result = opa ^ opb_sel;
      cpu_pkg::ALU_SLL: alu_result = opa << opb_sel[3:0];  // Shift by low 4 bits
      cpu_pkg::ALU_SRL: alu_result = opa >> opb_sel[3:0];
      default:          alu_result = opa + opb_sel;
    endcase
  end

  ////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////
  // Register operands compared directly, imm only feeds the target
  assign branch_taken  = is_branch && (opa == opb);
  assign branch_target = id_ex_pc_next + imm;

  // A BEQ has no register or memory side effect
  always_comb begin
    mem_out                         = mem_signals;
    mem_out[cpu_pkg::MEM_WR]        = mem_signals[cpu_pkg::MEM_WR] & ~is_branch;
    mem_out[cpu_pkg::MEM_RD]        = mem_signals[cpu_pkg::MEM_RD] & ~is_branch;
    wb_out                          = wb_signals;
    wb_out[cpu_pkg::WB_REG_WR]      = wb_signals[cpu_pkg::WB_REG_WR] & ~is_branch;
  end

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
////////////////////////////////////////
// Memory and writeback stage
// EX/MEM register, synchronous data memory, writeback select
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage #(
  parameter int dmem_addr_w = 8  // Data memory address bits
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       hold,
  input  logic [cpu_pkg::DATA_W-1:0] alu_result,
  input  logic [cpu_pkg::MEM_W-1:0]  mem_signals,
  input  logic [cpu_pkg::WB_W-1:0]   wb_signals,
  output logic                       wb_en,
  output logic [cpu_pkg::REG_W-1:0]  wb_reg,
  output logic [cpu_pkg::DATA_W-1:0] wb_data
);

  logic [cpu_pkg::DATA_W-1:0] dmem [1 << dmem_addr_w];
  logic [dmem_addr_w-1:0]     addr;          // Low bits of the effective address
  logic [cpu_pkg::DATA_W-1:0] alu_q, ld_q;   // EX/MEM payload
  logic [cpu_pkg::WB_W-1:0]   wb_q;          // EX/MEM control

  assign addr = alu_result[dmem_addr_w-1:0];

  // Memory access on the same edge that loads EX/MEM
  always_ff @(posedge clk) begin
    if (!hold) begin
      if (mem_signals[cpu_pkg::MEM_WR]) begin
        dmem[addr] <= mem_signals[cpu_pkg::MEM_SDATA_LSB +: cpu_pkg::DATA_W];
      end
      if (mem_signals[cpu_pkg::MEM_RD]) begin
        ld_q <= dmem[addr];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '0;
    end else if (!hold) begin
      wb_q <= wb_signals;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) alu_q <= alu_result;
  end

  assign wb_en   = wb_q[cpu_pkg::WB_REG_WR] & ~hold;  // No register write while frozen
  assign wb_reg  = wb_q[cpu_pkg::WB_DST_LSB +: cpu_pkg::REG_W];
  assign wb_data = wb_q[cpu_pkg::WB_FROM_MEM] ? ld_q : alu_q;

  assert property (@(posedge clk) disable iff (rst)
    !(mem_signals[cpu_pkg::MEM_RD] && mem_signals[cpu_pkg::MEM_WR]))
    else $error("mem_wb_stage: load and store in one slot");

endmodule

`default_nettype wire

//--- hw/cpu_core_top.sv
////////////////////////////////////////
// CPU core top
// Decode to writeback slice, fetch stays outside
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cpu_core_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [15:0]                instr,          // From fetch
  input  logic [cpu_pkg::DATA_W-1:0] pc_next,
  input  logic                       hold,           // Freeze everything
  output logic                       stall,          // Fetch repeats instr
  output logic                       branch_taken,
  output logic [cpu_pkg::DATA_W-1:0] branch_target,
  output logic                       wb_en,
  output logic [cpu_pkg::REG_W-1:0]  wb_reg,
  output logic [cpu_pkg::DATA_W-1:0] wb_data
);

  logic [cpu_pkg::REG_W-1:0]  rs1_idx, rs2_idx;
  logic [cpu_pkg::DATA_W-1:0] rs1_data, rs2_data;
  logic [cpu_pkg::EX_W-1:0]   ex_bundle, id_ex_ex;
  logic [cpu_pkg::MEM_W-1:0]  mem_bundle, id_ex_mem, ex_mem_in;
  logic [cpu_pkg::WB_W-1:0]   wb_bundle, id_ex_wb, ex_wb_in;
  logic [cpu_pkg::DATA_W-1:0] id_ex_pc_next, alu_result;
  logic                       src1_used, src2_used, flush;

  reg_file u_reg_file (
    .clk, .rst, .rs1_idx, .rs2_idx,
    .wr_en(wb_en), .wr_idx(wb_reg), .wr_data(wb_data),
    .rs1_data, .rs2_data
  );

  instr_decoder u_decoder (
    .instr, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
    .ex_bundle, .mem_bundle, .wb_bundle, .src1_used, .src2_used
  );

  // EX/MEM writer rebuilt from the writeback port
  hazard_unit u_hazard (
    .src1_idx(rs1_idx), .src2_idx(rs2_idx), .src1_used, .src2_used,
    .id_ex_wb, .ex_mem_wb({wb_reg, wb_en, 1'b0}),
    .branch_taken, .hold, .stall, .flush
  );

  id_ex_pipe_reg u_id_ex (
    .clk, .rst, .stall(hold), .flush, .pc_next,
    .ex_signals(ex_bundle), .mem_signals(mem_bundle), .wb_signals(wb_bundle),
    .id_ex_pc_next, .id_ex_ex_signals(id_ex_ex),
    .id_ex_mem_signals(id_ex_mem), .id_ex_wb_signals(id_ex_wb)
  );

  execute_unit u_execute (
    .ex_signals(id_ex_ex), .mem_signals(id_ex_mem), .wb_signals(id_ex_wb),
    .id_ex_pc_next, .alu_result, .branch_taken, .branch_target,
    .mem_out(ex_mem_in), .wb_out(ex_wb_in)
  );

  mem_wb_stage #(.dmem_addr_w(8)) u_mem_wb (
    .clk, .rst, .hold, .alu_result,
    .mem_signals(ex_mem_in), .wb_signals(ex_wb_in),
    .wb_en, .wb_reg, .wb_data
  );

endmodule

`default_nettype wire

//--- testbench/tb_isa_model.sv
////////////////////////////////////////
// ISA reference model
// Random program and its in-order write and branch sequence
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_isa_model #(
  parameter int n_instr  = 300,
  parameter int hold_len = 1000
) ();

  logic [15:0] prog [n_instr];
  logic [3:0]  exp_reg [n_instr];     // Register writes in program order
  logic [15:0] exp_val [n_instr];
  logic [15:0] exp_target [n_instr];  // Targets of taken BEQs, in order
  bit          hold_seq [hold_len];   // Hold level per cycle after reset
  int          n_writes;
  int          n_branches;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [15:0] sext4(input logic [3:0] v);
    return {{12{v[3]}}, v};
  endfunction

  initial begin : build
    logic [31:0] state;
    logic [15:0] rf [16];
    logic [15:0] dmem [256];
    bit          written [256];  // Addresses that a store has reached
    logic [15:0] word, a, b, imm, res;
    logic [7:0]  cand, addr;
    int          pc_exec;        // Next PC that really executes
    bit          found, wr;
    state      = 32'h7a95_ecad;
    n_writes   = 0;
    n_branches = 0;
    pc_exec    = 0;
    for (int i = 0; i < 16; i++) rf[i] = '0;  // Matches register file reset
    for (int i = 0; i < 256; i++) written[i] = 1'b0;
    for (int pc = 0; pc < n_instr; pc++) begin
      state = xorshift32(state);
      word  = {4'(state % 32'd13), state[27:16]};
      if (word[15:12] == cpu_pkg::OP_BEQ) begin
        word[3] = 1'b0;                            // Forward offsets only
        if (state[28]) word[7:4] = word[11:8];     // Same register so it is taken
      end
      if (pc == pc_exec) begin
        pc_exec = pc + 1;
        // Steer loads onto a stored address, else make them LI
        if (word[15:12] == cpu_pkg::OP_LD) begin
          found = 1'b0;
          for (int k = 0; k < 256 && !found; k++) begin
            cand  = state[31:24] + 8'(k);          // rs1 and imm4 candidate
            found = written[8'(rf[cand[7:4]] + sext4(cand[3:0]))];
            if (found) word[7:0] = cand;
          end
          if (!found) word[15:12] = cpu_pkg::OP_LI;
        end
        a    = rf[word[7:4]];
        b    = rf[word[3:0]];
        imm  = sext4(word[3:0]);
        addr = 8'(a + imm);                        // rs1 + imm4, low 8 bits
        wr   = 1'b1;
        case (cpu_pkg::opcode_e'(word[15:12]))
          cpu_pkg::OP_ADD:  res = a + b;
          cpu_pkg::OP_SUB:  res = a - b;
          cpu_pkg::OP_AND:  res = a & b;
          cpu_pkg::OP_OR:   res = a | b;
          cpu_pkg::OP_XOR:  res = a ^ b;
          cpu_pkg::OP_SLL:  res = a << b[3:0];
          cpu_pkg::OP_SRL:  res = a >> b[3:0];
          cpu_pkg::OP_ADDI: res = a + imm;
          cpu_pkg::OP_LI:   res = {{8{word[7]}}, word[7:0]};
          cpu_pkg::OP_LD:   res = dmem[addr];
          cpu_pkg::OP_ST: begin
            dmem[addr]    = rf[word[11:8]];        // Stores the rd field register
            written[addr] = 1'b1;
            wr            = 1'b0;
          end
          cpu_pkg::OP_BEQ: begin
            if (rf[word[11:8]] == a) begin
              exp_target[n_branches] = 16'(pc + 1) + imm;
              n_branches++;
              pc_exec = pc + 1 + int'(imm);        // Skipped words never execute
            end
            wr = 1'b0;
          end
          default: wr = 1'b0;                      // NOP
        endcase
        if (wr) begin
          exp_reg[n_writes] = word[11:8];
          exp_val[n_writes] = res;
          n_writes++;
          rf[word[11:8]] = res;
        end
      end
      prog[pc] = word;
    end
    // Hold pattern, about one cycle in ten
    for (int c = 0; c < hold_len; c++) begin
      state       = xorshift32(state);
      hold_seq[c] = (state % 32'd10 == 32'd0);
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_cpu_core.sv
////////////////////////////////////////
// CPU core testbench
// Fetch model, random hold and in-order write and branch checks
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

  localparam int N_INSTR      = 300;
  localparam int RESET_CYCLES = 10;
  localparam int WD_CYCLES    = N_INSTR * 4 + RESET_CYCLES + 50;  // Watchdog limit
  localparam int DRAIN_CYCLES = 6;   // Covers execute and writeback of the last word

  logic                       clk;
  logic                       rst;
  logic [15:0]                instr;
  logic [cpu_pkg::DATA_W-1:0] pc_next;
  logic                       hold;
  logic                       stall;
  logic                       branch_taken;
  logic [cpu_pkg::DATA_W-1:0] branch_target;
  logic                       wb_en;
  logic [cpu_pkg::REG_W-1:0]  wb_reg;
  logic [cpu_pkg::DATA_W-1:0] wb_data;

  int pc;        // Fetch PC, one word per instruction
  int cycle;
  int drain;
  int wr_idx;    // Next expected write
  int br_idx;    // Next expected taken branch
  bit accepted;  // First word has entered ID/EX

  cpu_core_top dut (
    .clk, .rst, .instr, .pc_next, .hold, .stall, .branch_taken, .branch_target,
    .wb_en, .wb_reg, .wb_data
  );

  tb_isa_model #(.n_instr(N_INSTR), .hold_len(WD_CYCLES)) model ();

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input int got, input int expected);
    stop_run($sformatf("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                       $time, sig, got, expected));
  endtask

  ////////////////////////////////////////
  // Fetch side and end of run
  ////////////////////////////////////////
  initial begin : stimulus
    rst     = 1'b1;
    hold    = 1'b0;
    instr   = 16'h0000;
    pc_next = 16'h0000;
    pc      = 0;
    cycle   = 0;
    drain   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (drain < DRAIN_CYCLES) begin
      hold    = (pc < N_INSTR && cycle < WD_CYCLES) ? model.hold_seq[cycle] : 1'b0;
      instr   = (pc < N_INSTR) ? model.prog[pc] : 16'h0000;  // NOPs past the end
      pc_next = 16'(pc + 1);
      #4;                                           // Just before the rising edge
      if (!hold) begin
        if (branch_taken) pc = int'(branch_target);  // Decode word is flushed
        else if (!stall) pc = pc + 1;
      end
      if (pc >= N_INSTR) drain = drain + 1;
      cycle = cycle + 1;
      @(negedge clk);
    end
    if (wr_idx == model.n_writes && br_idx == model.n_branches) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_run($sformatf("Program drained after %0d of %0d writes and %0d of %0d branches",
                         wr_idx, model.n_writes, br_idx, model.n_branches));
    end
  end

  ////////////////////////////////////////
  // Checks on the DUT outputs
  ////////////////////////////////////////
  initial begin : output_checks
    wr_idx   = 0;
    br_idx   = 0;
    accepted = 1'b0;
    forever begin
      @(negedge clk);
      #4;
      if (!rst) begin
        if (!accepted) begin                        // Empty pipeline after reset
          assert (!wb_en) else report_mismatch("wb_en", int'(wb_en), 0);
          assert (!stall) else report_mismatch("stall", int'(stall), 0);
          assert (!branch_taken) else report_mismatch("branch_taken", int'(branch_taken), 0);
          accepted = !hold;
        end
        if (hold) begin                             // Frozen pipeline
          assert (!wb_en) else report_mismatch("wb_en under hold", int'(wb_en), 0);
          assert (!stall) else report_mismatch("stall under hold", int'(stall), 0);
        end
        if (wb_en) begin
          if (wr_idx >= model.n_writes) begin
            stop_run("DUT wrote a register after the last write of the program");
          end else begin
            assert (wb_reg == model.exp_reg[wr_idx])
              else report_mismatch("wb_reg", int'(wb_reg), int'(model.exp_reg[wr_idx]));
            assert (wb_data == model.exp_val[wr_idx])
              else report_mismatch("wb_data", int'(wb_data), int'(model.exp_val[wr_idx]));
            wr_idx++;
          end
        end
        if (branch_taken) begin
          if (br_idx >= model.n_branches) begin
            stop_run("DUT took a branch that the program does not take");
          end else begin
            assert (branch_target == model.exp_target[br_idx])
              else report_mismatch("branch_target", int'(branch_target),
                                   int'(model.exp_target[br_idx]));
            if (!hold) br_idx++;                    // Redirect happens at this edge
          end
        end
      end
    end
  end

  // Watchdog
  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    stop_run("Timeout, the program did not drain in time");
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/hazard_unit.sv
hw/id_ex_pipe_reg.sv
hw/execute_unit.sv
hw/mem_wb_stage.sv
hw/cpu_core_top.sv
testbench/tb_isa_model.sv
testbench/tb_cpu_core.sv

//--- Makefile
# Verilator build and run of the CPU core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
